// ==== lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data path width of the core
`define LSU_XLEN 64

// byte address width, 64 KiB data space
`define LSU_ADDR_W 16

// one write strobe per byte lane
`define LSU_MASK_W 8

// sram access time in clk edges
`define LSU_WAIT_CYCLES 3

// 64-bit words, whole address space
`define LSU_MEM_WORDS 8192

`endif

// ==== lsu_pkg.sv ====
package lsu_pkg;

  // bits [1:0] give the access width, bit 2 selects zero extension
  typedef enum logic [2:0] {
    OP_LB  = 3'b000,  // byte, sign extended
    OP_LH  = 3'b001,  // halfword, sign extended
    OP_LW  = 3'b010,  // word, sign extended
    OP_LD  = 3'b011,  // doubleword
    OP_LBU = 3'b100,  // byte, zero extended
    OP_LHU = 3'b101,  // halfword, zero extended
    OP_LWU = 3'b110   // word, zero extended
  } mem_op_e;

  // access sequencer states
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // waiting for req
    ACCESS = 2'b01,  // sram busy, timer running
    RESP   = 2'b10,  // ack high until req drops
    DONE   = 2'b11   // ack low again
  } lsu_state_e;

endpackage

// ==== lsu_timer.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  output logic done
);
  localparam int CNT_W = (`LSU_WAIT_CYCLES < 2) ? 1 : $clog2(`LSU_WAIT_CYCLES + 1);

  logic [CNT_W-1:0] count;  // edges left before done
  logic             armed;  // a load has happened since reset

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
      armed <= 1'b0;
    end else if (load) begin
      count <= CNT_W'(`LSU_WAIT_CYCLES - 1);  // restart on every access
      armed <= 1'b1;
    end else if (count != '0) begin
      count <= count - 1'b1;              // stops at zero
    end
  end

  assign done = armed && (count == '0);  // stays high until next load

endmodule

// ==== lsu_store_align.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_store_align (
  input  lsu_pkg::mem_op_e        op,
  input  logic [2:0]              addr_lo,
  input  logic [`LSU_XLEN-1:0]    wdata,
  output logic [`LSU_XLEN-1:0]    ram_wdata,
  output logic [`LSU_MASK_W-1:0]  ram_wmask
);

  // store data copied into every lane, mask picks the real ones
  always_comb begin
    case (op[1:0])
      2'b00: begin
        ram_wdata = {8{wdata[7:0]}};                // byte in all lanes
        ram_wmask = `LSU_MASK_W'(1) << addr_lo;    // single lane
      end
      2'b01: begin
        ram_wdata = {4{wdata[15:0]}};
        ram_wmask = `LSU_MASK_W'(3) << {addr_lo[2:1], 1'b0};  // lane pair
      end
      2'b10: begin
        ram_wdata = {2{wdata[31:0]}};
        ram_wmask = addr_lo[2] ? 8'hf0 : 8'h0f;    // upper or lower half
      end
      default: begin
        ram_wdata = wdata;                          // full doubleword
        ram_wmask = '1;
      end
    endcase
  end

endmodule

// ==== lsu_load_align.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_load_align (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    capture,
  input  lsu_pkg::mem_op_e        op,
  input  logic [2:0]              addr_lo,
  input  logic [`LSU_XLEN-1:0]    ram_rdata,
  output logic [`LSU_XLEN-1:0]    rdata
);
  import lsu_pkg::*;

  logic [7:0]           b_sel;   // byte at addr_lo
  logic [15:0]          h_sel;   // halfword containing addr_lo
  logic [31:0]          w_sel;   // word containing addr_lo
  logic [`LSU_XLEN-1:0] ext;     // extended load value

  assign b_sel = ram_rdata[{addr_lo, 3'b000} +: 8];
  assign h_sel = ram_rdata[{addr_lo[2:1], 4'b0000} +: 16];
  assign w_sel = ram_rdata[{addr_lo[2], 5'b00000} +: 32];

  always_comb begin
    case (op)
      OP_LB:   ext = {{56{b_sel[7]}}, b_sel};   // sign extend
      OP_LH:   ext = {{48{h_sel[15]}}, h_sel};
      OP_LW:   ext = {{32{w_sel[31]}}, w_sel};
      OP_LBU:  ext = {56'h0, b_sel};            // zero extend
      OP_LHU:  ext = {48'h0, h_sel};
      OP_LWU:  ext = {32'h0, w_sel};
      default: ext = ram_rdata;                 // ld, whole word
    endcase
  end

  // result held for the whole handshake and beyond
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (capture) begin
      rdata <= ext;
    end
  end

endmodule

// ==== lsu_data_ram.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_data_ram (
  input  logic                              clk,
  input  logic                              en,
  input  logic                              we,
  input  logic [$clog2(`LSU_MEM_WORDS)-1:0] word_addr,
  input  logic [`LSU_XLEN-1:0]              wdata,
  input  logic [`LSU_MASK_W-1:0]            wmask,
  output logic [`LSU_XLEN-1:0]              rdata
);

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

  initial begin
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      mem[i] = '0;  // power-up contents
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int lane = 0; lane < `LSU_MASK_W; lane++) begin
          if (wmask[lane]) mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];  // masked lane
        end
      end
      rdata <= mem[word_addr];  // old contents on a write, unused then
    end
  end

endmodule

// ==== lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req,
  input  logic             we,
  input  lsu_pkg::mem_op_e op,
  input  logic [2:0]       addr_lo,
  input  logic             wait_done,
  output logic             ack,
  output logic             err,
  output logic             ram_en,
  output logic             ram_we,
  output logic             timer_load,
  output logic             capture
);
  import lsu_pkg::*;

  lsu_state_e state;
  lsu_state_e state_nxt;
  logic       aligned;  // natural alignment for the access width
  logic       start;    // req seen while able to accept

  always_comb begin
    case (op[1:0])
      2'b00:   aligned = 1'b1;               // byte never misaligned
      2'b01:   aligned = ~addr_lo[0];        // halfword
      2'b10:   aligned = addr_lo[1:0] == 2'b00;  // word
      default: aligned = addr_lo == 3'b000;  // doubleword
    endcase
  end

  // DONE accepts a new req too, so no edge is lost after ack drops
  assign start      = req && (state == IDLE || state == DONE);
  assign ram_en     = start && aligned;      // sram sees the access on the accept edge
  assign ram_we     = ram_en && we;
  assign timer_load = ram_en;                // latency starts with the sram access
  assign capture    = (state == ACCESS) && wait_done && !we;  // loads only

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE, DONE: begin
        if (req) begin
          state_nxt = aligned ? ACCESS : RESP;  // misaligned skips memory
        end else begin
          state_nxt = IDLE;
        end
      end
      ACCESS: if (wait_done) state_nxt = RESP;
      RESP:   if (!req) state_nxt = DONE;        // master released
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      ack   <= 1'b0;
      err   <= 1'b0;
    end else begin
      state <= state_nxt;
      ack   <= state_nxt == RESP;  // held through back-pressure
      if (state != RESP && state_nxt == RESP) begin
        err <= state != ACCESS;    // came straight from accept, so misaligned
      end
    end
  end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req,
  input  logic                    we,
  input  lsu_pkg::mem_op_e        op,
  input  logic [`LSU_ADDR_W-1:0]  addr,
  input  logic [`LSU_XLEN-1:0]    wdata,
  output logic                    ack,
  output logic [`LSU_XLEN-1:0]    rdata,
  output logic                    err
);
  localparam int WORD_W = $clog2(`LSU_MEM_WORDS);  // word index bits above the byte offset

  logic                   ram_en;      // one-cycle sram strobe
  logic                   ram_we;
  logic                   timer_load;
  logic                   wait_done;   // sram latency elapsed
  logic                   capture;     // load result strobe
  logic [`LSU_XLEN-1:0]   ram_wdata;
  logic [`LSU_MASK_W-1:0] ram_wmask;
  logic [`LSU_XLEN-1:0]   ram_rdata;

  lsu_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .we         (we),
    .op         (op),
    .addr_lo    (addr[2:0]),
    .wait_done  (wait_done),
    .ack        (ack),
    .err        (err),
    .ram_en     (ram_en),
    .ram_we     (ram_we),
    .timer_load (timer_load),
    .capture    (capture)
  );

  lsu_timer u_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (timer_load),
    .done  (wait_done)
  );

  lsu_store_align u_store_align (
    .op        (op),
    .addr_lo   (addr[2:0]),
    .wdata     (wdata),
    .ram_wdata (ram_wdata),
    .ram_wmask (ram_wmask)
  );

  lsu_data_ram u_ram (
    .clk       (clk),
    .en        (ram_en),
    .we        (ram_we),
    .word_addr (addr[3 +: WORD_W]),  // doubleword index
    .wdata     (ram_wdata),
    .wmask     (ram_wmask),
    .rdata     (ram_rdata)
  );

  lsu_load_align u_load_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .capture   (capture),
    .op        (op),
    .addr_lo   (addr[2:0]),
    .ram_rdata (ram_rdata),
    .rdata     (rdata)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0  // 250 MHz
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2.0) clk = ~clk;  // 50% duty

endmodule

// ==== tb_lsu_asserts.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu_asserts (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   req,
  input lsu_pkg::mem_op_e       op,
  input logic [`LSU_ADDR_W-1:0] addr,
  input logic                   ack,
  input logic                   err,
  input logic [`LSU_XLEN-1:0]   rdata,
  input logic                   ram_en
);
  import lsu_pkg::*;

  // sampled edges from the first req sample to the first ack sample
  localparam int ACK_LAT = `LSU_WAIT_CYCLES + 1;

  logic [2:0] low_mask;  // offset bits that must be clear for this width
  logic       aligned;
  int         fail_count = 0;  // failed assertions so far

  assign low_mask = 3'((4'd1 << op[1:0]) - 4'd1);
  assign aligned  = (addr[2:0] & low_mask) == 3'b000;

  reset_quiet: assert property (@(posedge clk) !rst_n |=> !ack && !err && rdata == '0)
    else begin
      fail_count++;
      $error("ack, err or rdata not cleared by reset");
    end

  aligned_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req) && aligned |-> !ack ##ACK_LAT ($rose(ack) && !err))
    else begin
      fail_count++;
      $error("aligned access ack not on the expected edge");
    end

  misaligned_reject: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req) && !aligned |-> !ack ##1 (ack && err))
    else begin
      fail_count++;
      $error("misaligned access not rejected one edge after req");
    end

  release_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req) |-> ack ##1 !ack)
    else begin
      fail_count++;
      $error("ack did not fall one edge after req dropped");
    end

  // master stalls with req still high
  hold_response: assert property (@(posedge clk) disable iff (!rst_n)
    ack && req |=> ack && $stable(rdata) && $stable(err))
    else begin
      fail_count++;
      $error("response changed while req was held");
    end

  no_access_in_resp: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> !ram_en)
    else begin
      fail_count++;
      $error("sram strobed while ack was high");
    end

  single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    ram_en |=> !ram_en)
    else begin
      fail_count++;
      $error("sram strobe longer than one cycle");
    end

endmodule

bind lsu_top tb_lsu_asserts u_asserts (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .op     (op),
  .addr   (addr),
  .ack    (ack),
  .err    (err),
  .rdata  (rdata),
  .ram_en (ram_en)
);

// ==== tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu;
  import lsu_pkg::*;

  typedef logic [`LSU_ADDR_W-1:0] addr_t;

  localparam int RESET_CYCLES = 5;
  localparam int N_RT     = 16;  // random sd/ld round trips
  localparam int N_NARROW = 4;   // words swept by narrow loads, 28 loads each
  localparam int N_MASK   = 8;   // sb, sh, sw then ld
  localparam int N_MIS    = 8;   // misaligned access then ld
  localparam int N_TRANS  = 2 * N_RT + 28 * N_NARROW + 4 * N_MASK + 2 * N_MIS;
  localparam int TIMEOUT_CYCLES = N_TRANS * (`LSU_WAIT_CYCLES + 6) + RESET_CYCLES + 4;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic                 we;
  mem_op_e              op;
  addr_t                addr;
  logic [`LSU_XLEN-1:0] wdata;
  logic                 ack;
  logic [`LSU_XLEN-1:0] rdata;
  logic                 err;

  logic [7:0] shadow [1 << `LSU_ADDR_W];  // byte image of the RAM
  addr_t      rt_addr [N_RT];             // doubleword addresses with known data
  int         cycles = 0;

  tb_clk_gen u_clk (.clk(clk));

  lsu_top uut (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .we    (we),
    .op    (op),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata),
    .err   (err)
  );

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // little-endian gather, sign fill for lb/lh/lw
  function automatic logic [63:0] expected_load(input mem_op_e o, input addr_t a);
    int         nbytes;
    logic [63:0] v;
    nbytes = 1 << o[1:0];
    v = '0;
    for (int i = 0; i < nbytes; i++) v[8*i +: 8] = shadow[a + addr_t'(i)];
    if (!o[2] && nbytes < 8 && v[8*nbytes-1]) v = v | (~64'h0 << (8 * nbytes));
    return v;
  endfunction

  task automatic shadow_write(input mem_op_e o, input addr_t a, input logic [63:0] d);
    int nbytes;
    nbytes = 1 << o[1:0];
    for (int i = 0; i < nbytes; i++) shadow[a + addr_t'(i)] = d[8*i +: 8];
  endtask

  // one four-phase handshake, entered and left on a falling edge
  task automatic run_access(input logic w, input mem_op_e o, input addr_t a,
                            input logic [63:0] d, output logic [63:0] got,
                            output logic got_err);
    int hold;
    hold = $urandom_range(2, 0);  // back-pressure cycles
    we    = w;
    op    = o;
    addr  = a;
    wdata = d;
    req   = 1'b1;
    do @(negedge clk); while (!ack);
    got     = rdata;
    got_err = err;
    repeat (hold) @(negedge clk);
    req = 1'b0;
    do @(negedge clk); while (ack);
  endtask

  task automatic store(input mem_op_e o, input addr_t a, input logic [63:0] d,
                       input string name);
    logic [63:0] got;
    logic        e;
    run_access(1'b1, o, a, d, got, e);
    check_value({name, " err"}, 64'd0, 64'(e));
    shadow_write(o, a, d);
  endtask

  task automatic load_and_check(input mem_op_e o, input addr_t a, input string name);
    logic [63:0] got;
    logic        e;
    run_access(1'b0, o, a, 64'h0, got, e);
    check_value({name, " err"}, 64'd0, 64'(e));
    check_value(name, expected_load(o, a), got);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (uut.u_asserts.fail_count != 0) begin
      $display("a protocol assertion in the bound checker failed");
      abort_run();
    end else if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    mem_op_e     narrow_ops [6];
    addr_t       base;
    logic [63:0] got;
    logic        e;
    mem_op_e     o;
    int          nb;
    int          off;
    void'($urandom(32'h3102_2224));
    narrow_ops = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU};
    rst_n = 1'b0;
    req   = 1'b0;
    we    = 1'b0;
    op    = OP_LB;
    addr  = '0;
    wdata = '0;
    for (int i = 0; i < (1 << `LSU_ADDR_W); i++) shadow[i] = 8'h00;  // RAM powers up zero
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("reset rdata", 64'h0, rdata);
    check_value("reset ack/err", 64'h0, {62'h0, ack, err});

    for (int i = 0; i < N_RT; i++) begin
      rt_addr[i] = addr_t'($urandom) & ~addr_t'(7);
      store(OP_LD, rt_addr[i], {$urandom, $urandom}, "round trip sd");
    end
    for (int i = 0; i < N_RT; i++) load_and_check(OP_LD, rt_addr[i], $sformatf("round trip ld %0d", i));

    for (int i = 0; i < N_NARROW; i++) begin
      for (int k = 0; k < 6; k++) begin
        nb = 1 << narrow_ops[k][1:0];
        for (off = 0; off < 8; off += nb) begin  // every legal offset
          load_and_check(narrow_ops[k], rt_addr[i] + addr_t'(off),
                         $sformatf("narrow %s +%0d", narrow_ops[k].name(), off));
        end
      end
    end

    for (int i = 0; i < N_MASK; i++) begin
      base = addr_t'($urandom) & ~addr_t'(7);
      store(OP_LB, base + addr_t'($urandom_range(7, 0)), {$urandom, $urandom}, "masked sb");
      store(OP_LH, base + addr_t'(2 * $urandom_range(3, 0)), {$urandom, $urandom}, "masked sh");
      store(OP_LW, base + addr_t'(4 * $urandom_range(1, 0)), {$urandom, $urandom}, "masked sw");
      load_and_check(OP_LD, base, "masked ld");
    end

    for (int i = 0; i < N_MIS; i++) begin
      base = rt_addr[i % N_RT];  // word with known contents
      o    = mem_op_e'(3'($urandom_range(3, 1)));
      nb   = 1 << o[1:0];
      off  = $urandom_range(7, 0);
      if ((off % nb) == 0) off = off + 1;  // force a misaligned offset
      run_access(1'($urandom), o, base + addr_t'(off), {$urandom, $urandom}, got, e);
      check_value($sformatf("misaligned %s +%0d err", o.name(), off), 64'd1, 64'(e));
      load_and_check(OP_LD, base, "misaligned ld");
    end

    if (uut.u_asserts.fail_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// ==== tb.f ====
+incdir+.
lsu_pkg.sv
lsu_timer.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_data_ram.sv
lsu_ctrl.sv
lsu_top.sv
tb_clk_gen.sv
tb_lsu_asserts.sv
tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu
RTL_TOP   ?= lsu_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/1ps -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
